/* run.sh */
#!/usr/bin/env bash
# build and run the hi/lo unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module mulDivUnitTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi

echo "simulation PASSED"

/* source/divStep.sv */
`timescale 1ns/1ps

// one restoring divide stage, BITS_PER_STAGE quotient bits per clock
module divStep import mdPkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  annul_i,   // drop whatever is in flight
	mdStageIf.dst inStage,
	mdStageIf.src outStage
);

	logic [ACC_WIDTH-1:0]  accNext;  // acc after this stage's iterations
	logic [DATA_WIDTH:0]   partRem;  // one extra bit for the shifted remainder
	logic                  doDiv;

	assign doDiv = inStage.valid && isDivOp(inStage.op);

	//////////////////////////////
	// shift, compare, subtract
	//////////////////////////////
	// acc = {rem, dividend/quot}, quotient bits shift in at the bottom
	always_comb begin
		accNext = inStage.acc;
		partRem = '0;
		for (int b = 0; b < BITS_PER_STAGE; b++) begin
			// rem shifted left with the next dividend bit
			partRem = {accNext[ACC_WIDTH-1 -: DATA_WIDTH], accNext[DATA_WIDTH-1]};
			accNext = {accNext[ACC_WIDTH-2:0], 1'b0};
			if (partRem >= {1'b0, inStage.divisor}) begin
				partRem    = partRem - {1'b0, inStage.divisor};
				accNext[0] = 1'b1;  // quotient bit set
			end
			// rem < divisor here, so it fits a word again
			accNext[ACC_WIDTH-1:DATA_WIDTH] = partRem[DATA_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset || annul_i) begin
			outStage.valid <= 1'b0;
		end else begin
			outStage.valid <= inStage.valid;
		end
	end

	// non-divide entries just ride along
	always_ff @(posedge clk) begin
		outStage.op      <= inStage.op;
		outStage.acc     <= doDiv ? accNext : inStage.acc;
		outStage.divisor <= inStage.divisor;
		outStage.negQuot <= inStage.negQuot;
		outStage.negRem  <= inStage.negRem;
	end

	// operand prep must never hand a zero divisor down the chain
	nonZeroDivisor: assert property (
		@(posedge clk) disable iff (reset)
		doDiv |-> inStage.divisor != '0
	) else $error("divStep: divide entry with zero divisor");

endmodule

/* source/hiloWriteback.sv */
`timescale 1ns/1ps

// retire end of the chain that owns hi / lo
module hiloWriteback import mdPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  annul_i,      // retiring entry dies too
	mdStageIf.dst                 inStage,
	output logic                  readValid_o,  // mf result for one cycle
	output logic [DATA_WIDTH-1:0] readData_o
);

	logic [DATA_WIDTH-1:0] hiReg;
	logic [DATA_WIDTH-1:0] loReg;
	logic [DATA_WIDTH-1:0] quotFix;  // signed quotient
	logic [DATA_WIDTH-1:0] remFix;   // signed remainder
	logic                  retire;   // entry commits this edge

	assign retire = inStage.valid && !annul_i;

	//////////////////////////////
	// divide sign fix
	//////////////////////////////
	assign quotFix = inStage.negQuot ? -inStage.acc[DATA_WIDTH-1:0]
	                                 : inStage.acc[DATA_WIDTH-1:0];
	assign remFix  = inStage.negRem ? -inStage.acc[ACC_WIDTH-1:DATA_WIDTH]
	                                : inStage.acc[ACC_WIDTH-1:DATA_WIDTH];

	// hi / lo registers
	always_ff @(posedge clk) begin
		if (reset) begin
			hiReg <= '0;
			loReg <= '0;
		end else if (retire) begin
			if (isMulOp(inStage.op)) begin
				hiReg <= inStage.acc[ACC_WIDTH-1:DATA_WIDTH];
				loReg <= inStage.acc[DATA_WIDTH-1:0];
			end else if (isDivOp(inStage.op)) begin
				hiReg <= remFix;   // remainder to hi
				loReg <= quotFix;  // quotient to lo
			end else if (inStage.op == MD_MTHI) begin
				hiReg <= inStage.acc[DATA_WIDTH-1:0];
			end else if (inStage.op == MD_MTLO) begin
				loReg <= inStage.acc[DATA_WIDTH-1:0];
			end
		end
	end

	//////////////////////////////
	// mf read port
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || annul_i) begin
			readValid_o <= 1'b0;
		end else begin
			readValid_o <= inStage.valid && isMfOp(inStage.op);
		end
	end

	// hi/lo already hold every older op since retire is in order
	always_ff @(posedge clk) begin
		if (retire && isMfOp(inStage.op)) begin
			readData_o <= (inStage.op == MD_MFHI) ? hiReg : loReg;
		end
	end

	// neither the flushed retiring mf nor the one behind it reaches the read port
	noReadAfterAnnul: assert property (
		@(posedge clk) disable iff (reset)
		(annul_i || $past(annul_i)) |=> !readValid_o
	) else $error("hiloWriteback: read result right after annul");

endmodule

/* source/mdOperandPrep.sv */
`timescale 1ns/1ps

// issue register feeding the first chain entry
module mdOperandPrep import mdPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  issueValid_i,  // new op this cycle
	input  mdOp_t                 issueOp_i,
	input  logic [DATA_WIDTH-1:0] srcA_i,        // rs
	input  logic [DATA_WIDTH-1:0] srcB_i,        // rt
	input  logic                  annul_i,       // flush kills this issue too
	mdStageIf.src                 outStage
);

	logic                  aNeg;       // sign of rs
	logic                  bNeg;       // sign of rt
	logic [DATA_WIDTH-1:0] aMag;
	logic [DATA_WIDTH-1:0] bMag;
	logic [ACC_WIDTH-1:0]  accIn;
	logic [DATA_WIDTH-1:0] divisorIn;
	logic                  negQuotIn;
	logic                  negRemIn;

	assign aNeg = srcA_i[DATA_WIDTH-1];
	assign bNeg = srcB_i[DATA_WIDTH-1];
	assign aMag = aNeg ? -srcA_i : srcA_i;  // two's complement magnitude
	assign bMag = bNeg ? -srcB_i : srcB_i;

	//////////////////////////////
	// per-op entry payload
	//////////////////////////////
	always_comb begin
		accIn     = '0;
		divisorIn = '0;
		negQuotIn = 1'b0;
		negRemIn  = 1'b0;
		case (issueOp_i)
			MD_MULT: begin
				// both operands signed and sign extended to 64
				accIn = $signed(srcA_i) * $signed(srcB_i);
			end
			MD_MULTU: begin
				accIn = srcA_i * srcB_i;  // zero extended
			end
			MD_DIV: begin
				accIn     = {{DATA_WIDTH{1'b0}}, aMag};  // rem starts at zero
				divisorIn = bMag;
				negQuotIn = aNeg ^ bNeg;  // signs differ
				negRemIn  = aNeg;         // rem follows dividend
			end
			MD_DIVU: begin
				accIn     = {{DATA_WIDTH{1'b0}}, srcA_i};
				divisorIn = srcB_i;
			end
			MD_MTHI, MD_MTLO: begin
				accIn = {{DATA_WIDTH{1'b0}}, srcA_i};  // value rides in low word
			end
			default: begin
				// nop and mf carry nothing
			end
		endcase
	end

	// flush also kills the op sampled this edge
	always_ff @(posedge clk) begin
		if (reset || annul_i) begin
			outStage.valid <= 1'b0;
		end else begin
			outStage.valid <= issueValid_i;
		end
	end

	// payload rides with the valid bit
	always_ff @(posedge clk) begin
		outStage.op      <= issueOp_i;
		outStage.acc     <= accIn;
		outStage.divisor <= divisorIn;
		outStage.negQuot <= negQuotIn;
		outStage.negRem  <= negRemIn;
	end

	// an issue slot always carries a real op
	validIssueOp: assert property (
		@(posedge clk) disable iff (reset)
		issueValid_i |-> issueOp_i != MD_NOP
	) else $error("mdOperandPrep: issue with MD_NOP");

endmodule

/* source/mdPkg.sv */
//////////////////////////////
// hi/lo unit shared defs
//////////////////////////////

package mdPkg;

	localparam int DATA_WIDTH     = 32;                       // gpr / hi / lo width
	localparam int ACC_WIDTH      = 2 * DATA_WIDTH;           // {hi, lo} sized accumulator
	localparam int NUM_STAGES     = 8;                        // divide stages in the chain
	localparam int BITS_PER_STAGE = DATA_WIDTH / NUM_STAGES;  // quotient bits per stage
	localparam int OP_WIDTH       = 4;                        // room for 9 codes

	// op codes carried with every entry
	typedef enum logic [OP_WIDTH-1:0] {
		MD_NOP   = 4'd0,
		MD_MULT  = 4'd1,
		MD_MULTU = 4'd2,
		MD_DIV   = 4'd3,
		MD_DIVU  = 4'd4,
		MD_MTHI  = 4'd5,
		MD_MTLO  = 4'd6,
		MD_MFHI  = 4'd7,
		MD_MFLO  = 4'd8
	} mdOp_t;

	// divide ops get the restoring iterations
	function automatic logic isDivOp(input mdOp_t op);
		return (op == MD_DIV) || (op == MD_DIVU);
	endfunction

	// mf ops produce a read result at retire
	function automatic logic isMfOp(input mdOp_t op);
		return (op == MD_MFHI) || (op == MD_MFLO);
	endfunction

	// multiplies write both halves straight from acc
	function automatic logic isMulOp(input mdOp_t op);
		return (op == MD_MULT) || (op == MD_MULTU);
	endfunction

endpackage

/* source/mdStageIf.sv */
`timescale 1ns/1ps

//////////////////////////////
// one pipeline entry
//////////////////////////////

// moves one stage per clock, no handshake, no back-pressure
interface mdStageIf;

	logic                         valid;    // live entry
	mdPkg::mdOp_t                 op;       // what to do at retire
	logic [mdPkg::ACC_WIDTH-1:0]  acc;      // {rem, quot} for divides, product, or mt value
	logic [mdPkg::DATA_WIDTH-1:0] divisor;  // magnitude only
	logic                         negQuot;  // flip quotient sign at retire
	logic                         negRem;   // flip remainder sign at retire

	// driver side
	modport src (
		output valid, op, acc, divisor, negQuot, negRem
	);

	// receiver side
	modport dst (
		input valid, op, acc, divisor, negQuot, negRem
	);

endinterface

/* source/mulDivUnit.sv */
`timescale 1ns/1ps

//////////////////////////////
// hi/lo mult / div unit top
//////////////////////////////

// fixed latency NUM_STAGES+1, every op through the same chain
module mulDivUnit import mdPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  issueValid_i,  // op accepted every cycle this is high
	input  mdOp_t                 issueOp_i,
	input  logic [DATA_WIDTH-1:0] srcA_i,
	input  logic [DATA_WIDTH-1:0] srcB_i,
	input  logic                  annul_i,       // exception flush
	output logic                  readValid_o,
	output logic [DATA_WIDTH-1:0] readData_o
);

	// stageBus[0] from prep, stageBus[NUM_STAGES] into writeback
	mdStageIf stageBus [0:NUM_STAGES] ();

	mdOperandPrep prepI (
		.clk          (clk),
		.reset        (reset),
		.issueValid_i (issueValid_i),
		.issueOp_i    (issueOp_i),
		.srcA_i       (srcA_i),
		.srcB_i       (srcB_i),
		.annul_i      (annul_i),
		.outStage     (stageBus[0])
	);

	// divide chain
	genvar s;
	generate
		for (s = 0; s < NUM_STAGES; s++) begin : gDivStage
			divStep divStepI (
				.clk      (clk),
				.reset    (reset),
				.annul_i  (annul_i),
				.inStage  (stageBus[s]),
				.outStage (stageBus[s+1])  // next stage in
			);
		end
	endgenerate

	hiloWriteback writebackI (
		.clk         (clk),
		.reset       (reset),
		.annul_i     (annul_i),
		.inStage     (stageBus[NUM_STAGES]),
		.readValid_o (readValid_o),
		.readData_o  (readData_o)
	);

endmodule

/* tb/mulDivUnitTb.sv */
`timescale 1ns/1ps

// directed testbench for the hi/lo unit, checks reads in issue order
module mulDivUnitTb import mdPkg::*; ();

	logic                  clk;
	logic                  reset;
	logic                  issueValid;
	mdOp_t                 issueOp;
	logic [DATA_WIDTH-1:0] srcA;
	logic [DATA_WIDTH-1:0] srcB;
	logic                  annul;
	logic                  readValid;
	logic [DATA_WIDTH-1:0] readData;

	logic [DATA_WIDTH-1:0] expHi;          // reference hi, updated at issue
	logic [DATA_WIDTH-1:0] expLo;          // reference lo
	logic [DATA_WIDTH-1:0] expQ [$];       // pending mf results in issue order
	int                    edgeQ [$];      // edge each pending mf should retire on
	int                    edgeCount = 0;  // rising edges seen so far
	int                    errors = 0;
	int unsigned           lcgState = 3656;
	string                 curTest = "reset";

	mulDivUnit uut (
		.clk          (clk),
		.reset        (reset),
		.issueValid_i (issueValid),
		.issueOp_i    (issueOp),
		.srcA_i       (srcA),
		.srcB_i       (srcB),
		.annul_i      (annul),
		.readValid_o  (readValid),
		.readData_o   (readData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	always @(posedge clk) edgeCount <= edgeCount + 1;

	// hard stop if something hangs
	initial begin
		#200000;
		$display("Timeout: simulation did not reach the end, %0d errors", errors);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState ^ (lcgState >> 15);  // fold high bits down
	endfunction

	// {hi, lo} of a 64 bit product
	function automatic logic [63:0] mulModel(input mdOp_t op, input logic [31:0] a, b);
		logic [63:0] ea;
		logic [63:0] eb;
		ea = (op == MD_MULT) ? {{32{a[31]}}, a} : {32'b0, a};
		eb = (op == MD_MULT) ? {{32{b[31]}}, b} : {32'b0, b};
		return ea * eb;  // low 64 bits are right for both signednesses
	endfunction

	// {rem, quot}, truncating toward zero
	function automatic logic [63:0] divModel(input mdOp_t op, input logic [31:0] a, b);
		longint sa;
		longint sb;
		longint q;
		longint r;
		sa = (op == MD_DIV) ? {{32{a[31]}}, a} : {32'b0, a};
		sb = (op == MD_DIV) ? {{32{b[31]}}, b} : {32'b0, b};
		q  = sa / sb;
		r  = sa % sb;  // sign of dividend
		return {r[31:0], q[31:0]};
	endfunction

	//////////////////////////////
	// drive helpers
	//////////////////////////////
	task automatic sendOp(input mdOp_t op, input logic [31:0] a, input logic [31:0] b);
		issueValid = 1'b1;
		issueOp    = op;
		srcA       = a;
		srcB       = b;
		case (op)
			MD_MULT, MD_MULTU: {expHi, expLo} = mulModel(op, a, b);
			MD_DIV, MD_DIVU:   {expHi, expLo} = divModel(op, a, b);
			MD_MTHI:           expHi = a;
			MD_MTLO:           expLo = a;
			MD_MFHI, MD_MFLO: begin
				expQ.push_back((op == MD_MFHI) ? expHi : expLo);
				edgeQ.push_back(edgeCount + NUM_STAGES + 2);  // issue edge plus 9
			end
			default: ;
		endcase
		@(posedge clk);
		#1;
		issueValid = 1'b0;  // next call may raise it again right away
		issueOp    = MD_NOP;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// wait for every pending mf to come back
	task automatic waitReads();
		int t;
		t = 0;
		while (expQ.size() != 0 && t < 4 * NUM_STAGES) begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (expQ.size() == 0) else begin
			errors++;
			$display("%s: timed out with %0d reads still missing", curTest, expQ.size());
		end
	endtask

	// read port checker, sampled mid cycle
	always @(negedge clk) begin : readMonitor
		logic [31:0] expVal;
		int          expEdge;
		if (!reset && readValid) begin
			assert (expQ.size() != 0) else begin
				errors++;
				$display("%s: read result appeared with no MF outstanding", curTest);
			end
			if (expQ.size() != 0) begin
				expVal  = expQ.pop_front();
				expEdge = edgeQ.pop_front();
				assert (readData === expVal) else begin
					errors++;
					$display("Error: %s expected %h actual %h", curTest, expVal, readData);
				end
				assert (edgeCount == expEdge) else begin
					errors++;
					$display("Error: %s retire edge expected %0d actual %0d",
					         curTest, expEdge, edgeCount);
				end
			end
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic testMoveRoundTrip();
		curTest = "moveRoundTrip";
		sendOp(MD_MFHI, 0, 0);  // zero after reset
		sendOp(MD_MFLO, 0, 0);
		sendOp(MD_MTHI, nextRand(), 0);
		sendOp(MD_MTLO, nextRand(), 0);
		sendOp(MD_MFHI, 0, 0);
		sendOp(MD_MFLO, 0, 0);
		waitReads();
	endtask

	task automatic testMultiply();
		logic [31:0] a;
		logic [31:0] b;
		curTest = "multiply";
		sendOp(MD_MULT, 32'hFFFF_FFF9, 32'd13);  // -7 * 13
		sendOp(MD_MFHI, 0, 0);
		sendOp(MD_MFLO, 0, 0);
		for (int i = 0; i < 8; i++) begin
			a = nextRand();
			b = nextRand();
			sendOp(i[0] ? MD_MULTU : MD_MULT, a, b);
			sendOp(MD_MFHI, 0, 0);
			sendOp(MD_MFLO, 0, 0);
		end
		waitReads();
	endtask

	task automatic testDivide();
		logic [31:0] a;
		logic [31:0] b;
		curTest = "divide";
		sendOp(MD_DIV, 32'hFFFF_FFF9, 32'd2);  // -7 / 2
		sendOp(MD_MFHI, 0, 0);
		sendOp(MD_MFLO, 0, 0);
		sendOp(MD_DIV, 32'd7, 32'hFFFF_FFFE);  // 7 / -2
		sendOp(MD_MFHI, 0, 0);
		sendOp(MD_MFLO, 0, 0);
		for (int i = 0; i < 8; i++) begin
			a = nextRand();
			b = nextRand() >> (i * 3);  // small divisors too
			if (b == 0) b = 1;
			sendOp(i[0] ? MD_DIVU : MD_DIV, a, b);
			sendOp(MD_MFHI, 0, 0);
			sendOp(MD_MFLO, 0, 0);
		end
		waitReads();
	endtask

	// one op and one mf every cycle, latency checked by the monitor
	task automatic testBackToBack();
		logic [31:0] a;
		logic [31:0] b;
		mdOp_t       op;
		curTest = "backToBack";
		for (int i = 0; i < 12; i++) begin
			a = nextRand();
			b = nextRand();
			if (b == 0) b = 1;
			case (nextRand() % 6)
				0:       op = MD_MULT;
				1:       op = MD_MULTU;
				2:       op = MD_DIV;
				3:       op = MD_DIVU;
				4:       op = MD_MTHI;
				default: op = MD_MTLO;
			endcase
			sendOp(op, a, b);
			sendOp(nextRand() % 2 == 0 ? MD_MFHI : MD_MFLO, 0, 0);
		end
		waitReads();
	endtask

	task automatic testAnnul();
		logic [31:0] savedHi;
		logic [31:0] savedLo;
		curTest = "annul";
		sendOp(MD_MTHI, nextRand(), 0);
		sendOp(MD_MTLO, nextRand(), 0);
		idleCycles(NUM_STAGES + 2);  // let the moves retire
		savedHi = expHi;
		savedLo = expLo;
		sendOp(MD_DIV, nextRand(), 32'd5);
		sendOp(MD_MFLO, 0, 0);
		idleCycles(3);
		annul = 1'b1;
		@(posedge clk);
		#1;
		annul = 1'b0;
		expHi = savedHi;  // flushed work never happened
		expLo = savedLo;
		expQ.delete();
		edgeQ.delete();
		idleCycles(NUM_STAGES + 4);  // monitor flags any stray read
		sendOp(MD_MFHI, 0, 0);
		sendOp(MD_MFLO, 0, 0);
		waitReads();
	endtask

	initial begin
		reset      = 1'b1;
		issueValid = 1'b0;
		issueOp    = MD_NOP;
		srcA       = '0;
		srcB       = '0;
		annul      = 1'b0;
		expHi      = '0;
		expLo      = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (readValid === 1'b0) else begin
			errors++;
			$display("reset: read valid is not low after reset");
		end
		testMoveRoundTrip();
		testMultiply();
		testDivide();
		testBackToBack();
		testAnnul();
		idleCycles(2);
		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
source/mdPkg.sv
source/mdStageIf.sv
source/mdOperandPrep.sv
source/divStep.sv
source/hiloWriteback.sv
source/mulDivUnit.sv
tb/mulDivUnitTb.sv
